// ==== Bender.yml ====
package:
  name: frame_board

sources:
  # Packages first, then RTL from leaves to top
  - hdl/frame_cfg_pkg.sv
  - hdl/frame_bus_pkg.sv
  - hdl/board_reset.sv
  - hdl/joy_map.sv
  - hdl/snd_dac.sv
  - hdl/rom_download.sv
  - hdl/frame_board.sv
  - target: test
    files:
      - test/frame_board_tb.sv

// ==== frame_board.f ====
hdl/frame_cfg_pkg.sv
hdl/frame_bus_pkg.sv
hdl/board_reset.sv
hdl/joy_map.sv
hdl/snd_dac.sv
hdl/rom_download.sv
hdl/frame_board.sv
test/frame_board_tb.sv

// ==== hdl/board_reset.sv ====
// Releases the system reset cleanly and stretches the game reset over all of its causes
module board_reset (
    input  logic clk_rgb,
    input  logic rst_n,
    input  logic dip_flip,      // Any change restarts the game
    input  logic rst_req,
    input  logic downloading,
    output logic rst,
    output logic game_rst
);
    import frame_cfg_pkg::*;
    import frame_bus_pkg::*;

    logic                 rst_meta;
    logic                 dip_last;
    logic                 cause;
    rst_state_e           state;
    logic [RST_CNT_W-1:0] cnt;

    // Asynchronous assertion and release after two edges
    always_ff @(posedge clk_rgb or negedge rst_n) begin
        if (!rst_n) begin
            rst_meta <= 1'b1;
            rst      <= 1'b1;
        end else begin
            rst_meta <= 1'b0;
            rst      <= rst_meta;
        end
    end

    always_ff @(posedge clk_rgb) begin
        dip_last <= dip_flip;
    end

    assign cause = rst_req | (dip_flip ^ dip_last) | downloading;

    // HOLD takes one edge to leave, so COUNT runs RST_CYCLES-1 edges
    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            state <= RST_HOLD;
            cnt   <= '0;
        end else if (cause) begin
            state <= RST_HOLD;   // Restart from scratch
            cnt   <= '0;
        end else begin
            case (state)
                RST_HOLD: begin
                    state <= RST_COUNT;
                    cnt   <= '0;
                end
                RST_COUNT: begin
                    if (cnt == RST_CNT_W'(RST_CYCLES - 2)) state <= RST_RUN;
                    else cnt <= cnt + 1'b1;
                end
                default: state <= RST_RUN;
            endcase
        end
    end

    assign game_rst = (state != RST_RUN);

    // The game reset never ends sooner than RST_CYCLES after the system reset or a cause
    a_game_stretch: assert property (@(posedge clk_rgb)
        $fell(game_rst) |-> !$past(rst || cause, RST_CYCLES))
        else $error("game_rst fell less than RST_CYCLES cycles after its last cause");

endmodule

// ==== hdl/frame_board.sv ====
// Board-support top level, place it next to the game core and tie it to the platform ports
module frame_board #(
    parameter bit SIGNED_SND    = 1'b0,
    parameter bit THREE_BUTTONS = 1'b0
) (
    input  logic                            clk_rgb,
    input  logic                            rst_n,
    // Reset causes
    input  logic                            dip_flip,   // A change forces a game reset
    input  logic                            rst_req,
    // Controls
    input  frame_bus_pkg::board_joy_t       board_joy1,
    input  frame_bus_pkg::board_joy_t       board_joy2,
    input  logic                            pause_btn,
    // Sound
    input  logic [frame_cfg_pkg::SND_W-1:0] snd,
    // ROM download
    input  frame_bus_pkg::ioctl_t           ioctl,
    input  logic                            ioctl_download,
    input  logic                            mem_credit,
    output logic                            rst,
    output logic                            game_rst,
    output logic                            downloading,
    // Game inputs, active low
    output logic [frame_cfg_pkg::JOY_W-1:0] game_joy1,
    output logic [frame_cfg_pkg::JOY_W-1:0] game_joy2,
    output logic [1:0]                      game_coin,
    output logic [1:0]                      game_start,
    output logic                            game_pause,
    output logic                            audio_l,
    output logic                            audio_r,
    output frame_bus_pkg::mem_wr_t          mem_wr,
    output logic                            mem_wr_valid
);

    assign audio_r = audio_l;   // Mono game

    board_reset u_reset (
        .clk_rgb     ( clk_rgb     ),
        .rst_n       ( rst_n       ),
        .dip_flip    ( dip_flip    ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    )
    );

    joy_map #(.THREE_BUTTONS(THREE_BUTTONS)) u_joy (
        .clk_rgb     ( clk_rgb     ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    ),
        .board_joy1  ( board_joy1  ),
        .board_joy2  ( board_joy2  ),
        .pause_btn   ( pause_btn   ),
        .game_joy1   ( game_joy1   ),
        .game_joy2   ( game_joy2   ),
        .game_coin   ( game_coin   ),
        .game_start  ( game_start  ),
        .game_pause  ( game_pause  )
    );

    snd_dac #(.SIGNED_SND(SIGNED_SND)) u_dac (
        .clk_rgb     ( clk_rgb     ),
        .rst         ( rst         ),
        .snd         ( snd         ),
        .audio       ( audio_l     )
    );

    rom_download u_dl (
        .clk_rgb        ( clk_rgb        ),
        .rst            ( rst            ),
        .ioctl          ( ioctl          ),
        .ioctl_download ( ioctl_download ),
        .mem_wr         ( mem_wr         ),
        .mem_wr_valid   ( mem_wr_valid   ),
        .mem_credit     ( mem_credit     ),
        .downloading    ( downloading    )
    );

endmodule

// ==== hdl/frame_bus_pkg.sv ====
// Structs and FSM state types shared by the board blocks and the testbench
package frame_bus_pkg;

    // Board joystick word, all bits active high
    typedef struct packed {
        logic       coin;     // Bit 9
        logic       start;    // Bit 8
        logic [3:0] button;   // Bits 7 to 4, button 1 in bit 4
        logic       up;
        logic       down;
        logic       left;
        logic       right;    // Bit 0
    } board_joy_t;

    // One byte of the ROM download stream
    typedef struct packed {
        logic [frame_cfg_pkg::ADDR_W-1:0] addr;
        logic [7:0]                       data;
        logic                             wr;   // Byte strobe
    } ioctl_t;

    // One word write towards memory
    typedef struct packed {
        logic [frame_cfg_pkg::WADDR_W-1:0] addr;   // Word address
        logic [frame_cfg_pkg::WORD_W-1:0]  data;
        logic [frame_cfg_pkg::MASK_W-1:0]  mask;   // Bit 0 enables the low byte
    } mem_wr_t;

    // Game reset sequencer
    typedef enum logic [1:0] {
        RST_HOLD,    // A cause is present
        RST_COUNT,   // Causes gone, stretching
        RST_RUN
    } rst_state_e;

    // Download byte packer
    typedef enum logic [1:0] {
        DL_IDLE,
        DL_LOW,     // Even byte held, waiting for its pair
        DL_FLUSH    // Push the held half word
    } dl_state_e;

endpackage

// ==== hdl/frame_cfg_pkg.sv ====
// Sizing constants for the board layer, imported by every RTL block and the testbench
package frame_cfg_pkg;

    // Download stream byte address
    localparam int ADDR_W = 22;

    // Game sound sample and DAC accumulator
    localparam int SND_W = 16;
    localparam int DAC_W = 8;   // Top bits of snd that reach the DAC

    // Board and game joystick words
    localparam int JOY_W = 10;

    // Game reset stretch after the last cause clears
    localparam int RST_CYCLES = 16;
    localparam int RST_CNT_W  = $clog2(RST_CYCLES);

    // Memory write port
    localparam int CREDITS = 4;   // Also the write FIFO depth
    localparam int FIFO_AW = $clog2(CREDITS);
    localparam int CRED_W  = $clog2(CREDITS + 1);   // Holds 0 to CREDITS

    // Memory side word address, one bit less than the byte address
    localparam int WADDR_W = ADDR_W - 1;

    // Memory word and byte lanes
    localparam int WORD_W = 16;
    localparam int MASK_W = WORD_W / 8;

endpackage

// ==== hdl/joy_map.sv ====
// Turns the board joystick words into active-low game inputs and keeps the pause toggle
module joy_map #(
    parameter bit THREE_BUTTONS = 1'b0   // Game has no fourth button
) (
    input  logic                             clk_rgb,
    input  logic                             rst,
    input  logic                             game_rst,
    input  frame_bus_pkg::board_joy_t        board_joy1,
    input  frame_bus_pkg::board_joy_t        board_joy2,
    input  logic                             pause_btn,
    output logic [frame_cfg_pkg::JOY_W-1:0]  game_joy1,
    output logic [frame_cfg_pkg::JOY_W-1:0]  game_joy2,
    output logic [1:0]                       game_coin,
    output logic [1:0]                       game_start,
    output logic                             game_pause
);
    import frame_cfg_pkg::*;
    import frame_bus_pkg::*;

    logic pause_last;

    // Directions and buttons inverted, top two bits idle
    function automatic logic [JOY_W-1:0] map_joy(input board_joy_t j);
        logic [JOY_W-1:0] g;
        g = {2'b11, ~j.button, ~j.up, ~j.down, ~j.left, ~j.right};
        if (THREE_BUTTONS) g[7] = 1'b1;   // Button 4 never pressed
        return g;
    endfunction

    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            game_joy1  <= '1;
            game_joy2  <= '1;
            game_coin  <= 2'b11;
            game_start <= 2'b11;
        end else begin
            game_joy1  <= map_joy(board_joy1);
            game_joy2  <= map_joy(board_joy2);
            game_coin  <= ~{board_joy2.coin, board_joy1.coin};
            game_start <= ~{board_joy2.start, board_joy1.start};
        end
    end

    // Pause flips on each press
    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            pause_last <= 1'b0;
            game_pause <= 1'b0;
        end else begin
            pause_last <= pause_btn;
            if (game_rst) begin
                game_pause <= 1'b0;
            end else if (pause_btn && !pause_last) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

// ==== hdl/rom_download.sv ====
// Packs the ROM download byte stream into 16-bit writes and sends them out under credits
module rom_download (
    input  logic                   clk_rgb,
    input  logic                   rst,
    input  frame_bus_pkg::ioctl_t  ioctl,
    input  logic                   ioctl_download,
    output frame_bus_pkg::mem_wr_t mem_wr,
    output logic                   mem_wr_valid,
    input  logic                   mem_credit,   // One word finished
    output logic                   downloading
);
    import frame_cfg_pkg::*;
    import frame_bus_pkg::*;

    dl_state_e           state, state_nx;
    mem_wr_t             word_q, word_nx;   // Partial word
    mem_wr_t             lo_word, hi_word, push_word;
    logic                push, pop, fifo_full;
    mem_wr_t             fifo_mem [CREDITS];
    logic [FIFO_AW-1:0]  wr_ptr, rd_ptr;
    logic [CRED_W-1:0]   fifo_cnt, credits;

    function automatic logic [FIFO_AW-1:0] ptr_inc(input logic [FIFO_AW-1:0] p);
        return (p == FIFO_AW'(CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    // Incoming byte placed in its lane
    assign lo_word = '{addr: ioctl.addr[ADDR_W-1:1], data: {8'h00, ioctl.data}, mask: 2'b01};
    assign hi_word = '{addr: ioctl.addr[ADDR_W-1:1], data: {ioctl.data, 8'h00}, mask: 2'b10};

    always_comb begin
        state_nx  = state;
        word_nx   = word_q;
        push      = 1'b0;
        push_word = word_q;
        case (state)
            DL_IDLE: if (ioctl.wr) begin
                if (ioctl.addr[0]) begin   // Lone odd byte
                    push      = 1'b1;
                    push_word = hi_word;
                end else begin
                    word_nx  = lo_word;
                    state_nx = DL_LOW;
                end
            end
            DL_LOW: if (ioctl.wr) begin
                push = 1'b1;
                if (ioctl.addr == {word_q.addr, 1'b1}) begin
                    push_word = '{addr: word_q.addr, data: {ioctl.data, word_q.data[7:0]},
                                  mask: 2'b11};
                    state_nx  = DL_IDLE;
                end else if (ioctl.addr[0]) begin   // Break onto an odd byte
                    word_nx  = hi_word;
                    state_nx = DL_FLUSH;
                end else begin
                    word_nx = lo_word;   // Break onto a new even byte
                end
            end else if (!ioctl_download) begin
                state_nx = DL_FLUSH;
            end
            DL_FLUSH: begin
                push     = 1'b1;
                state_nx = DL_IDLE;
            end
            default: state_nx = DL_IDLE;
        endcase
    end

    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) state <= DL_IDLE;
        else     state <= state_nx;
    end

    always_ff @(posedge clk_rgb) begin
        word_q <= word_nx;
        if (push) fifo_mem[wr_ptr] <= push_word;
    end

    assign fifo_full    = (fifo_cnt == CRED_W'(CREDITS));
    assign pop          = (fifo_cnt != '0) && (credits != '0);
    assign mem_wr       = fifo_mem[rd_ptr];
    assign mem_wr_valid = pop;

    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            credits  <= CRED_W'(CREDITS);
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            fifo_cnt <= fifo_cnt + CRED_W'(push) - CRED_W'(pop);
            credits  <= credits - CRED_W'(pop) + CRED_W'(mem_credit);
        end
    end

    // Busy until every word has been written back
    assign downloading = ioctl_download | (state != DL_IDLE) | (fifo_cnt != '0)
                       | (credits != CRED_W'(CREDITS));

    a_no_overflow: assert property (@(posedge clk_rgb) disable iff (rst) push |-> !fifo_full)
        else $error("Write FIFO push while full");
    a_credit_max: assert property (@(posedge clk_rgb) disable iff (rst)
        credits <= CRED_W'(CREDITS))
        else $error("More credits returned than granted");
    // Spending the last credit with none coming back leaves the port quiet
    a_valid_credit: assert property (@(posedge clk_rgb) disable iff (rst)
        mem_wr_valid && credits == CRED_W'(1) && !mem_credit |=> !mem_wr_valid)
        else $error("Write sent without a credit");

endmodule

// ==== hdl/snd_dac.sv ====
// First-order sigma-delta DAC that turns the game sound into a one-bit audio stream
module snd_dac #(
    parameter bit SIGNED_SND = 1'b0   // Two's complement input
) (
    input  logic                            clk_rgb,
    input  logic                            rst,
    input  logic [frame_cfg_pkg::SND_W-1:0] snd,
    output logic                            audio
);
    import frame_cfg_pkg::*;

    logic [DAC_W-1:0] dac_in;   // Offset binary, top bits only
    logic [DAC_W-1:0] acc;

    // Flipping the MSB turns signed samples into offset binary
    always_ff @(posedge clk_rgb) begin
        dac_in <= {snd[SND_W-1] ^ SIGNED_SND, snd[SND_W-2 -: DAC_W-1]};
    end

    // Carry out is the pulse density output
    always_ff @(posedge clk_rgb or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            audio <= 1'b0;
        end else begin
            {audio, acc} <= {1'b0, acc} + {1'b0, dac_in};
        end
    end

endmodule

// ==== test/frame_board_tb.sv ====
// Testbench for the board layer, run with frame_board_tb as top and the project file list
module frame_board_tb;
    import frame_cfg_pkg::*;
    import frame_bus_pkg::*;

    localparam logic [31:0] SEED = 32'hb58d9654;

    logic              clk_rgb = 1'b0;
    logic              rst_n;
    logic              dip_flip;
    logic              rst_req;
    board_joy_t        board_joy1;
    board_joy_t        board_joy2;
    logic              pause_btn;
    logic [SND_W-1:0]  snd;
    ioctl_t            ioctl;
    logic              ioctl_download;
    logic              mem_credit;
    logic              rst, game_rst, downloading;
    logic [JOY_W-1:0]  game_joy1, game_joy2;
    logic [1:0]        game_coin, game_start;
    logic              game_pause, audio_l, audio_r;
    mem_wr_t           mem_wr;
    logic              mem_wr_valid;

    logic [31:0]       rng;
    logic [31:0]       mem_rng;       // Separate stream for the memory model
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                test_errors = 0;
    int                mem_cyc = 0;
    int                due_idx;
    int                credit_due[$];  // Cycle at which each credit goes back
    mem_wr_t           mem_q[$];
    mem_wr_t           exp_q[$];
    logic [ADDR_W-1:0] dl_addr[$];
    logic [7:0]        dl_data[$];

    frame_board uut (
        .clk_rgb(clk_rgb), .rst_n(rst_n), .dip_flip(dip_flip), .rst_req(rst_req),
        .board_joy1(board_joy1), .board_joy2(board_joy2), .pause_btn(pause_btn),
        .snd(snd), .ioctl(ioctl), .ioctl_download(ioctl_download),
        .mem_credit(mem_credit), .rst(rst), .game_rst(game_rst),
        .downloading(downloading), .game_joy1(game_joy1), .game_joy2(game_joy2),
        .game_coin(game_coin), .game_start(game_start), .game_pause(game_pause),
        .audio_l(audio_l), .audio_r(audio_r), .mem_wr(mem_wr), .mem_wr_valid(mem_wr_valid)
    );

    always #50 clk_rgb = ~clk_rgb;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Game words are active low, top two joystick bits idle
    function automatic logic [23:0] exp_joy(input logic [9:0] j1, input logic [9:0] j2);
        logic [9:0] g1;
        logic [9:0] g2;
        g1 = {2'b11, ~j1[7:0]};
        g2 = {2'b11, ~j2[7:0]};
        return {g1, g2, ~j2[9], ~j1[9], ~j2[8], ~j1[8]};
    endfunction

    function automatic int exp_audio_ones(input logic [SND_W-1:0] v);
        return int'(v[SND_W-1 -: DAC_W]);
    endfunction

    // Pairs even bytes with the next consecutive odd byte, anything else goes alone
    function automatic void exp_words();
        int i;
        exp_q.delete();
        i = 0;
        while (i < dl_addr.size()) begin
            if (dl_addr[i][0]) begin
                exp_q.push_back(mem_wr_t'({dl_addr[i][ADDR_W-1:1], dl_data[i], 8'h00, 2'b10}));
                i++;
            end else if (i + 1 < dl_addr.size() && dl_addr[i+1] == dl_addr[i] + 1'b1) begin
                exp_q.push_back(mem_wr_t'({dl_addr[i][ADDR_W-1:1], dl_data[i+1], dl_data[i],
                                           2'b11}));
                i += 2;
            end else begin
                exp_q.push_back(mem_wr_t'({dl_addr[i][ADDR_W-1:1], 8'h00, dl_data[i], 2'b01}));
                i++;
            end
        end
    endfunction

    // Just after the rising edge, where inputs change and outputs are read
    task automatic tick();
        @(posedge clk_rgb);
        #1;
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) $display("Test %s: ok", name);
        else $display("Test %s: %0d error(s)", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic cycles_to_game_run(input string what, output int n);
        n = 0;
        while (game_rst !== 1'b0 && n < 100) begin
            tick();
            n++;
        end
        if (game_rst !== 1'b0) begin
            $display("Timeout: game_rst never fell after %s", what);
            errors++;
        end
    endtask

    task automatic pulse_cause(input string name, input bit use_dip);
        int n;
        if (use_dip) dip_flip = ~dip_flip;
        else rst_req = 1'b1;
        tick();
        check({name, " raises game_rst"}, 1, game_rst);
        rst_req = 1'b0;
        cycles_to_game_run(name, n);
        check({name, " game_rst stretch"}, RST_CYCLES, n);
    endtask

    // Memory model, logs each write and returns its credit 1 to 6 cycles later
    always @(posedge clk_rgb) begin
        #1;
        mem_cyc++;
        mem_credit = 1'b0;
        due_idx = -1;
        for (int i = 0; i < credit_due.size(); i++) begin
            if (due_idx < 0 && credit_due[i] <= mem_cyc) due_idx = i;
        end
        if (due_idx >= 0) begin
            credit_due.delete(due_idx);
            mem_credit = 1'b1;   // One credit per cycle at most
        end
        if (mem_wr_valid === 1'b1) begin
            mem_q.push_back(mem_wr);
            mem_rng = lcg(mem_rng);
            credit_due.push_back(mem_cyc + 1 + int'(mem_rng[31:16] % 6));
        end
    end

    initial begin : main
        int                n, ones, lapses, len, brk, gap;
        logic [SND_W-1:0]  v;
        logic [9:0]        j1, j2;
        logic [ADDR_W-1:0] base;
        bit                exp_pause;
        rng            = SEED;
        mem_rng        = ~SEED;
        rst_n          = 1'b0;
        dip_flip       = 1'b0;
        rst_req        = 1'b0;
        board_joy1     = '0;
        board_joy2     = '0;
        pause_btn      = 1'b0;
        snd            = '0;
        ioctl          = '0;
        ioctl_download = 1'b0;
        mem_credit     = 1'b0;

        repeat (8) begin
            tick();
            check("reset values", {2'b11, 5'b0, 24'hff_ffff}, {rst, game_rst, mem_wr_valid,
                  downloading, game_pause, audio_l, audio_r, game_joy1, game_joy2,
                  game_coin, game_start});
        end
        rst_n = 1'b1;
        cycles_to_game_run("rst_n release", n);
        check("reset release", RST_CYCLES + 2, n);   // Two synchroniser edges first
        end_test("reset");

        pulse_cause("rst_req", 1'b0);
        pulse_cause("dip_flip", 1'b1);
        end_test("reset causes");

        repeat (40) begin
            rng = lcg(rng);
            j1 = rng[31:22];
            j2 = rng[21:12];
            board_joy1 = j1;
            board_joy2 = j2;
            tick();
            check("joystick map", exp_joy(j1, j2), {game_joy1, game_joy2, game_coin, game_start});
        end
        exp_pause = 1'b0;
        repeat (3) begin
            pause_btn = 1'b1;
            tick();
            pause_btn = 1'b0;
            tick();
            exp_pause = ~exp_pause;
            check("pause toggle", exp_pause, game_pause);
        end
        rst_req = 1'b1;
        tick();
        rst_req = 1'b0;
        cycles_to_game_run("pause clear", n);
        check("pause cleared by game reset", 0, game_pause);
        end_test("joystick");

        repeat (5) begin
            rng = lcg(rng);
            v = rng[31:16];
            snd = v;
            repeat (2) tick();   // Input register and accumulator settle
            ones = 0;
            lapses = 0;
            repeat (256) begin
                tick();
                if (audio_l === 1'b1) ones++;
                if (audio_r !== audio_l) lapses++;
            end
            check("audio density", exp_audio_ones(v), ones);
            check("audio right channel", 0, lapses);
        end
        end_test("audio");

        // Odd length stream with one address break
        rng = lcg(rng);
        len = 2 * (5 + int'(rng[31:16] % 8)) + 1;
        brk = 1 + int'(rng[31:16] % (len - 1));
        gap = 2 + int'(rng[15:8] % 40);
        rng = lcg(rng);
        base = ADDR_W'(rng[31:12]) & ~ADDR_W'(1);
        for (int i = 0; i < len; i++) begin
            rng = lcg(rng);
            dl_addr.push_back(base + ADDR_W'(i) + ((i >= brk) ? ADDR_W'(gap) : ADDR_W'(0)));
            dl_data.push_back(rng[31:24]);
        end
        exp_words();
        lapses = 0;
        ioctl_download = 1'b1;
        tick();
        for (int i = 0; i < len; i++) begin
            if (downloading !== 1'b1 || game_rst !== 1'b1) lapses++;
            ioctl = '{addr: dl_addr[i], data: dl_data[i], wr: 1'b1};
            tick();
            if (downloading !== 1'b1 || game_rst !== 1'b1) lapses++;
            ioctl.wr = 1'b0;   // One byte every two cycles
            tick();
        end
        ioctl_download = 1'b0;
        n = 0;
        while (downloading !== 1'b0 && n < 300) begin
            tick();
            n++;
            if (game_rst !== 1'b1) lapses++;
        end
        if (downloading !== 1'b0) begin
            $display("Timeout: downloading never fell after the download ended");
            errors++;
        end
        check("credits back when downloading falls", 0, credit_due.size());
        check("busy through download", 0, lapses);
        cycles_to_game_run("download", n);
        check("game_rst after download", RST_CYCLES, n);
        end_test("download reset");

        check("word count", exp_q.size(), mem_q.size());
        for (int i = 0; i < exp_q.size() && i < mem_q.size(); i++) begin
            check("memory word", exp_q[i], mem_q[i]);
        end
        end_test("download words");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
